// File: cache_array_if.sv
// controller to array link
`timescale 1ns/100ps
`include "dcache_defines.svh"

interface cache_array_if import dcache_pkg::*; ();

  logic [`DC_INDEX_BITS-1:0]    index;      // set read every cycle
  logic [`DC_WAYS-1:0]          fill_way;   // one-hot refill write
  logic [`DC_TAG_BITS-1:0]      fill_tag;   // also the lookup tag
  line_t                        fill_line;
  logic [`DC_WAYS-1:0]          store_way;  // one-hot store write
  logic [$clog2(`DC_WORDS)-1:0] store_word;
  logic [3:0]                   store_wstrb;
  logic [31:0]                  store_wdata;

  // lookup results, one cycle after index
  logic [`DC_WAYS-1:0]                    way_hit;
  logic [`DC_WAYS-1:0][`DC_TAG_BITS-1:0]  way_tag;
  logic [`DC_WAYS-1:0]                    way_valid;
  line_t [`DC_WAYS-1:0]                   way_line;

  modport ctrl (
    output index, fill_way, fill_tag, fill_line,
    output store_way, store_word, store_wstrb, store_wdata,
    input  way_hit, way_tag, way_line
  );

  modport tag (
    input  index, fill_way, fill_tag,
    output way_hit, way_tag, way_valid
  );

  modport data (
    input  index, fill_way, fill_line, store_way, store_word, store_wstrb, store_wdata,
    output way_line
  );

endinterface

// File: cache_ctrl.sv
// data cache controller
`timescale 1ns/100ps
`include "dcache_defines.svh"

module cache_ctrl import dcache_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  // processor side
  input  logic         req_valid,
  input  logic         req_op,     // 1 = store
  input  logic [31:0]  req_addr,
  input  logic [3:0]   req_wstrb,
  input  logic [31:0]  req_wdata,
  output logic         addr_ok,
  output logic         data_ok,
  output logic [31:0]  rdata,
  // memory side
  output logic         mem_rd_req,
  output logic [31:0]  mem_rd_addr,
  input  logic         mem_rd_rdy,
  input  logic         mem_ret_valid,
  input  line_t        mem_ret_data,
  output logic         mem_wr_req,
  output logic [31:0]  mem_wr_addr,
  output line_t        mem_wr_data,
  input  logic         mem_wr_rdy,
  input  logic         mem_wr_valid,
  cache_array_if.ctrl  arr
);

  ctrl_state_e state, state_nxt;

  addr_u       new_a;    // incoming address
  addr_u       req_a;    // request register
  addr_u       fill_a;   // line address of the miss
  addr_u       victim_a; // line address of the evicted line
  logic        req_op_r;
  logic [3:0]  req_wstrb_r;
  logic [31:0] req_wdata_r;

  logic [`DC_SETS-1:0]               victim_bit; // way to replace next, per set
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty;

  logic                         accept;
  logic                         hit;
  logic                         hit_way;
  logic                         victim_way;
  logic [$clog2(`DC_WORDS)-1:0] word_sel;

  assign new_a.addr = req_addr;
  assign hit        = |arr.way_hit;
  assign hit_way    = arr.way_hit[1];
  assign victim_way = victim_bit[req_a.f.index];
  assign word_sel   = req_a.f.offset[`DC_OFFSET_BITS-1:2];

  // loads pipeline behind a load hit, stores and misses block
  assign addr_ok = (state == IDLE) || (state == LOOKUP && hit && !req_op_r);
  assign accept  = req_valid && addr_ok;

  assign data_ok = (state == LOOKUP) && hit;
  assign rdata   = arr.way_line[hit_way][word_sel];

  always_ff @(posedge clk) begin
    if (accept) begin
      req_a       <= new_a;
      req_op_r    <= req_op;
      req_wstrb_r <= req_wstrb;
      req_wdata_r <= req_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:       if (accept) state_nxt = LOOKUP;
      LOOKUP: begin
        if (!hit)
          state_nxt = dirty[victim_way][req_a.f.index] ? MISS_DIRTY : MISS_CLEAN;
        else if (req_op_r)
          state_nxt = STORE;
        else if (accept)
          state_nxt = LOOKUP;  // back-to-back load
        else
          state_nxt = IDLE;
      end
      STORE:      state_nxt = IDLE;
      MISS_DIRTY: if (mem_wr_rdy) state_nxt = WRITEBACK;
      WRITEBACK:  if (mem_wr_valid) state_nxt = MISS_CLEAN;
      MISS_CLEAN: if (mem_rd_rdy) state_nxt = REFILL;
      REFILL:     if (mem_ret_valid) state_nxt = REPLAY;
      REPLAY:     state_nxt = LOOKUP;  // arrays now show the new line
      default:    state_nxt = IDLE;
    endcase
  end

  // victim points away from the way that just hit
  always_ff @(posedge clk) begin
    if (reset) begin
      victim_bit <= '0;
      dirty      <= '0;
    end else if (state == LOOKUP && hit) begin
      victim_bit[req_a.f.index] <= ~hit_way;
      if (req_op_r)
        dirty[hit_way][req_a.f.index] <= 1'b1;
    end else if (state == REFILL && mem_ret_valid) begin
      dirty[victim_way][req_a.f.index] <= 1'b0;
    end
  end

  // array side, index held on the request set unless a new one is taken
  assign arr.index       = accept ? new_a.f.index : req_a.f.index;
  assign arr.fill_way    = (state == REFILL && mem_ret_valid) ? (2'b01 << victim_way) : '0;
  assign arr.fill_tag    = req_a.f.tag;
  assign arr.fill_line   = mem_ret_data;
  assign arr.store_way   = (state == STORE) ? arr.way_hit : '0; // set re-read, same hit
  assign arr.store_word  = word_sel;
  assign arr.store_wstrb = req_wstrb_r;
  assign arr.store_wdata = req_wdata_r;

  always_comb begin
    fill_a            = req_a;
    fill_a.f.offset   = '0;
    victim_a.f.tag    = arr.way_tag[victim_way];
    victim_a.f.index  = req_a.f.index;
    victim_a.f.offset = '0;
  end

  // memory side
  assign mem_rd_req  = (state == MISS_CLEAN);
  assign mem_rd_addr = fill_a.addr;
  assign mem_wr_req  = (state == MISS_DIRTY);
  assign mem_wr_addr = victim_a.addr;
  assign mem_wr_data = arr.way_line[victim_way];

endmodule

// File: data_store.sv
// line data arrays
`timescale 1ns/100ps
`include "dcache_defines.svh"

module data_store import dcache_pkg::*; (
  input logic          clk,
  cache_array_if.data  arr
);

  line_t lines [`DC_WAYS][`DC_SETS];

  // refill writes the whole line, a store only the strobed bytes of one word
  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (arr.fill_way[w]) begin
        lines[w][arr.index] <= arr.fill_line;
      end else if (arr.store_way[w]) begin
        for (int b = 0; b < 4; b++) begin
          if (arr.store_wstrb[b])
            lines[w][arr.index][arr.store_word][8*b +: 8] <= arr.store_wdata[8*b +: 8];
        end
      end
    end
  end

  // read port, old data on a same-cycle write
  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++)
      arr.way_line[w] <= lines[w][arr.index];
  end

endmodule

// File: dcache_defines.svh
// data cache geometry
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address split, tag | index | offset
`define DC_TAG_BITS    20
`define DC_INDEX_BITS  8
`define DC_OFFSET_BITS 4

// 256 sets of 16-byte lines
`define DC_SETS  256
`define DC_WORDS 4  // 32-bit words per line

// two-way set associative
`define DC_WAYS  2

`endif

// File: dcache_pkg.sv
// data cache types
`include "dcache_defines.svh"

package dcache_pkg;

  // one address word, seen flat toward memory or split for the arrays
  typedef union packed {
    logic [31:0] addr;
    struct packed {
      logic [`DC_TAG_BITS-1:0]    tag;
      logic [`DC_INDEX_BITS-1:0]  index;
      logic [`DC_OFFSET_BITS-1:0] offset;
    } f;
  } addr_u;

  // whole cache line, word 0 in the low bits
  typedef logic [`DC_WORDS-1:0][31:0] line_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,     // array outputs valid, hit decided here
    STORE,      // byte-strobe write of a store hit
    MISS_DIRTY, // victim write request pending
    WRITEBACK,  // waiting for write done
    MISS_CLEAN, // refill read request pending
    REFILL,     // waiting for the returned line
    REPLAY      // re-read the set after the fill
  } ctrl_state_e;

endpackage

// File: dcache_tb.sv
// data cache testbench
`timescale 1ns/100ps

module dcache_tb import dcache_pkg::*; ();

  localparam int clk_period = 8;
  localparam int num_random = 300;
  localparam int num_reqs   = 10 + num_random;  // directed requests first

  typedef struct packed {
    logic        store;
    logic [31:0] addr;
    logic [31:0] data;
  } exp_t;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic        req_op;
  logic [31:0] req_addr;
  logic [3:0]  req_wstrb;
  logic [31:0] req_wdata;
  logic        addr_ok;
  logic        data_ok;
  logic [31:0] rdata;
  logic        mem_rd_req;
  logic [31:0] mem_rd_addr;
  logic        mem_rd_rdy;
  logic        mem_ret_valid;
  line_t       mem_ret_data;
  logic        mem_wr_req;
  logic [31:0] mem_wr_addr;
  line_t       mem_wr_data;
  logic        mem_wr_rdy;
  logic        mem_wr_valid;

  logic [31:0] model [logic [29:0]];  // expected memory image of stored words
  exp_t        exp_q [$];             // requests waiting for data_ok
  exp_t        cur = '0;              // response of the current cycle
  logic        resp_ok = 1'b0;
  line_t       wr_exp_line;
  logic        expect_hit;            // directed request to a resident line
  logic        acc;
  integer      seed = 32'h672b_2da8;

  assign acc = req_valid && addr_ok;

  dcache_top dut (.*);

  tb_memory u_mem (.*);

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [31:0] model_word(input logic [29:0] waddr);
    if (model.exists(waddr))
      return model[waddr];
    return {2'b00, waddr} ^ 32'h5a5a_0000;
  endfunction

  function automatic line_t model_line(input logic [31:0] addr);
    line_t l;
    for (int w = 0; w < 4; w++)
      l[w] = model_word({addr[31:4], w[1:0]});
    return l;
  endfunction

  // apply the request to the image and queue its response
  task automatic record_request(input logic op, input logic [31:0] addr,
                                input logic [3:0] strb, input logic [31:0] wdata);
    logic [31:0] word;
    exp_t        e;
    word = model_word(addr[31:2]);
    if (op) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b])
          word[8*b +: 8] = wdata[8*b +: 8];
      end
      model[addr[31:2]] = word;
    end
    e.store = op;
    e.addr  = addr;
    e.data  = word;
    exp_q.push_back(e);
  endtask

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic issue(input logic op, input logic [31:0] addr, input logic [3:0] strb,
                       input logic [31:0] wdata, input logic hit);
    req_valid  = 1'b1;
    req_op     = op;
    req_addr   = addr;
    req_wstrb  = strb;
    req_wdata  = wdata;
    expect_hit = hit;
    @(negedge clk);
    while (!addr_ok)
      @(negedge clk);
    record_request(op, addr, strb, wdata);
    @(posedge clk);
    #1;
    req_valid  = 1'b0;
    expect_hit = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // sample the response queue where outputs are stable
  always @(negedge clk) begin
    if (mem_wr_req)
      wr_exp_line = model_line(mem_wr_addr);
    resp_ok = 1'b0;
    if (data_ok && exp_q.size() != 0) begin
      cur     = exp_q.pop_front();
      resp_ok = 1'b1;
    end
  end

  initial begin
    #(num_reqs * 200 * clk_period);
    report_error("watchdog timeout, the requests did not all complete");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req_op     = 1'b0;
    req_addr   = '0;
    req_wstrb  = '0;
    req_wdata  = '0;
    expect_hit = 1'b0;
    idle_cycles(16);
    reset = 1'b0;
    idle_cycles(2);

    issue(1'b0, 32'h0000_1000, 4'h0, 32'h0, 1'b0);  // cold miss
    issue(1'b0, 32'h0000_1000, 4'h0, 32'h0, 1'b1);
    issue(1'b0, 32'h0000_1000, 4'h0, 32'h0, 1'b1);  // three hits back to back
    issue(1'b0, 32'h0000_1004, 4'h0, 32'h0, 1'b1);
    issue(1'b0, 32'h0000_1008, 4'h0, 32'h0, 1'b1);
    issue(1'b1, 32'h0000_1004, 4'b0101, 32'hdead_beef, 1'b1);
    issue(1'b0, 32'h0000_1004, 4'h0, 32'h0, 1'b1);
    // third line in the same set pushes out the dirty one
    issue(1'b0, 32'h0000_3000, 4'h0, 32'h0, 1'b0);
    issue(1'b0, 32'h0000_5000, 4'h0, 32'h0, 1'b0);
    issue(1'b0, 32'h0000_1004, 4'h0, 32'h0, 1'b0);

    // 4 tags x 4 sets x 4 words
    for (int i = 0; i < num_random; i++) begin
      r = $random(seed);
      a = {16'h0002, 2'b00, r[1:0], 6'h00, r[3:2], r[5:4], 2'b00};
      issue(r[6], a, r[10:7], $random(seed), 1'b0);
      if (r[12:11] == 2'b00)
        idle_cycles(1);
    end

    while (exp_q.size() != 0)
      @(negedge clk);
    idle_cycles(4);
    $display("ALL TESTS PASSED");
    $finish;
  end

  assert property (@(posedge clk) $past(reset) && !reset |->
                   addr_ok && !data_ok && !mem_rd_req && !mem_wr_req)
    else report_error("outputs not idle after reset");

  assert property (@(posedge clk) disable iff (reset) data_ok |-> resp_ok)
    else report_error("data_ok without an outstanding request");

  assert property (@(posedge clk) disable iff (reset)
                   data_ok && !cur.store |-> rdata == cur.data)
    else report_error($sformatf("load from %h returned wrong data, expected %h",
                                cur.addr, cur.data));

  assert property (@(posedge clk) disable iff (reset)
                   mem_rd_req |-> mem_rd_addr[3:0] == 4'h0 && !addr_ok)
    else report_error("refill address not line aligned or addr_ok high during miss");

  assert property (@(posedge clk) disable iff (reset) mem_wr_req |->
                   mem_wr_addr[3:0] == 4'h0 && mem_wr_data == wr_exp_line && !addr_ok)
    else report_error($sformatf("writeback of line %h differs from the image",
                                mem_wr_addr));

  // hit timing
  assert property (@(posedge clk) disable iff (reset) $past(acc && expect_hit) |-> data_ok)
    else report_error("hit response not one cycle after acceptance");

  assert property (@(posedge clk) disable iff (reset)
                   $past(acc && expect_hit && !req_op) |-> addr_ok)
    else report_error("load hit did not keep addr_ok high");

  assert property (@(posedge clk) disable iff (reset)
                   $past(acc && expect_hit && req_op) || $past(acc && expect_hit && req_op, 2)
                   |-> !addr_ok)
    else report_error("addr_ok high during store hit");

  assert property (@(posedge clk) disable iff (reset)
                   $past(acc && expect_hit && req_op, 3) |-> addr_ok)
    else report_error("cache not ready two cycles after store hit");

endmodule

// File: dcache_top.sv
// two-way data cache top
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         req_valid,
  input  logic         req_op,
  input  logic [31:0]  req_addr,
  input  logic [3:0]   req_wstrb,
  input  logic [31:0]  req_wdata,
  output logic         addr_ok,
  output logic         data_ok,
  output logic [31:0]  rdata,
  output logic         mem_rd_req,
  output logic [31:0]  mem_rd_addr,
  input  logic         mem_rd_rdy,
  input  logic         mem_ret_valid,
  input  line_t        mem_ret_data,
  output logic         mem_wr_req,
  output logic [31:0]  mem_wr_addr,
  output line_t        mem_wr_data,
  input  logic         mem_wr_rdy,
  input  logic         mem_wr_valid
);

  cache_array_if arr ();

  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_wstrb     (req_wstrb),
    .req_wdata     (req_wdata),
    .addr_ok       (addr_ok),
    .data_ok       (data_ok),
    .rdata         (rdata),
    .mem_rd_req    (mem_rd_req),
    .mem_rd_addr   (mem_rd_addr),
    .mem_rd_rdy    (mem_rd_rdy),
    .mem_ret_valid (mem_ret_valid),
    .mem_ret_data  (mem_ret_data),
    .mem_wr_req    (mem_wr_req),
    .mem_wr_addr   (mem_wr_addr),
    .mem_wr_data   (mem_wr_data),
    .mem_wr_rdy    (mem_wr_rdy),
    .mem_wr_valid  (mem_wr_valid),
    .arr           (arr.ctrl)
  );

  tag_store u_tags (
    .clk   (clk),
    .reset (reset),
    .arr   (arr.tag)
  );

  data_store u_data (
    .clk (clk),
    .arr (arr.data)
  );

endmodule

// File: filelist.f
+incdir+.
dcache_pkg.sv
cache_array_if.sv
tag_store.sv
data_store.sv
cache_ctrl.sv
dcache_top.sv
tb_memory.sv
dcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module dcache_tb -f filelist.f -o dcache_sim

# show the output and keep it for the pass check
out=$(./obj_dir/dcache_sim 2>&1 | tee /dev/stderr)

grep -q "ALL TESTS PASSED" <<< "$out"

// File: tag_store.sv
// tag and valid arrays
`timescale 1ns/100ps
`include "dcache_defines.svh"

module tag_store (
  input logic         clk,
  input logic         reset,
  cache_array_if.tag  arr
);

  logic [`DC_TAG_BITS-1:0]           tags [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid;

  // tag ram, read registered like a block ram
  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (arr.fill_way[w])
        tags[w][arr.index] <= arr.fill_tag;
      arr.way_tag[w] <= tags[w][arr.index];
    end
  end

  // valid bits live in flops so they can clear
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (arr.fill_way[w])
          valid[w][arr.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++)
      arr.way_valid[w] <= valid[w][arr.index];
  end

  // fill_tag carries the registered request tag
  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++)
      arr.way_hit[w] = arr.way_valid[w] && (arr.way_tag[w] == arr.fill_tag);
  end

endmodule

// File: tb_memory.sv
// cache testbench memory model
`timescale 1ns/100ps

module tb_memory import dcache_pkg::*; (
  input  logic        clk,
  input  logic        mem_rd_req,
  input  logic [31:0] mem_rd_addr,
  output logic        mem_rd_rdy,
  output logic        mem_ret_valid,
  output line_t       mem_ret_data,
  input  logic        mem_wr_req,
  input  logic [31:0] mem_wr_addr,
  input  line_t       mem_wr_data,
  output logic        mem_wr_rdy,
  output logic        mem_wr_valid
);

  integer seed = 32'h672b_2da8;
  line_t  shadow [logic [31:0]];  // lines written back so far, by line address

  // unwritten words hold their word address xor a fixed pattern
  function automatic line_t read_line(input logic [31:0] line_addr);
    line_t l;
    if (shadow.exists(line_addr))
      return shadow[line_addr];
    for (int w = 0; w < 4; w++)
      l[w] = {2'b00, line_addr[31:4], w[1:0]} ^ 32'h5a5a_0000;
    return l;
  endfunction

  function automatic int pick_delay();
    int r;
    r = $random(seed);
    return r & 3;  // 0 to 3 cycles
  endfunction

  // all outputs change 1 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin : read_port
    logic [31:0] addr;
    mem_rd_rdy    = 1'b0;
    mem_ret_valid = 1'b0;
    mem_ret_data  = '0;
    forever begin
      wait_cycles(1);
      if (mem_rd_req) begin
        wait_cycles(pick_delay());
        mem_rd_rdy = 1'b1;
        addr       = mem_rd_addr;  // held by the cache until accepted
        wait_cycles(1);
        mem_rd_rdy = 1'b0;
        wait_cycles(pick_delay());  // line returns 1 to 4 cycles later
        mem_ret_valid = 1'b1;
        mem_ret_data  = read_line(addr);
        wait_cycles(1);
        mem_ret_valid = 1'b0;
      end
    end
  end

  initial begin : write_port
    mem_wr_rdy   = 1'b0;
    mem_wr_valid = 1'b0;
    forever begin
      wait_cycles(1);
      if (mem_wr_req) begin
        wait_cycles(pick_delay());
        mem_wr_rdy = 1'b1;
        shadow[mem_wr_addr] = mem_wr_data;
        wait_cycles(1);
        mem_wr_rdy = 1'b0;
        wait_cycles(pick_delay());
        mem_wr_valid = 1'b1;  // write done strobe
        wait_cycles(1);
        mem_wr_valid = 1'b0;
      end
    end
  end

endmodule
